// File: hw/stas_macros.svh
`ifndef STAS_MACROS_SVH
`define STAS_MACROS_SVH

// ------------------------------
// Bus widths
// ------------------------------

// AXI4-Lite address width
`define STAS_ADDR_W 7
// Data width of the bus and of every queue entry
`define STAS_DATA_W 32
// One strobe per byte lane
`define STAS_STRB_W 4

// ------------------------------
// Queue geometry
// ------------------------------

`define STAS_DEPTH 32
`define STAS_IDX_W 5
// One bit wider than the index so a full queue (32) fits
`define STAS_CNT_W 6
// Entries are word addressed, byte offset bits are skipped
`define STAS_IDX_LSB 2

`endif

// File: hw/stas_pkg.sv
package stas_pkg;

	// Write channel states
	typedef enum logic [1:0]
	{
		WR_IDLE   = 2'd0,
		WR_ACCEPT = 2'd1,
		WR_RESP   = 2'd2
	} wr_state_t;

	// Read channel states
	typedef enum logic [1:0]
	{
		RD_IDLE   = 2'd0,
		RD_ACCEPT = 2'd1,
		RD_DATA   = 2'd2
	} rd_state_t;

	// Queue operation for one clock cycle
	typedef enum logic [1:0]
	{
		Q_HOLD     = 2'd0,
		Q_PUSH     = 2'd1,
		Q_POP      = 2'd2,
		Q_PUSH_POP = 2'd3
	} q_op_t;

endpackage

// File: hw/stas_axi_fsm.sv
`timescale 1ns/1ns
`include "stas_macros.svh"

module stas_axi_fsm
(
	input  logic                      S1_AXI_ACLK,
	input  logic                      S1_AXI_ARESETN,
	// Write address and data channels
	input  logic                      awvalid,
	output logic                      awready,
	input  logic                      wvalid,
	output logic                      wready,
	// Write response channel
	output logic                      bvalid,
	input  logic                      bready,
	// Read address channel
	input  logic                      arvalid,
	input  logic [`STAS_ADDR_W-1:0]   araddr,
	output logic                      arready,
	// Read data channel
	output logic                      rvalid,
	output logic [`STAS_DATA_W-1:0]   rdata,
	input  logic                      rready,
	// Queue side
	output logic                      wr_commit,
	output logic                      rd_capture,
	output logic [`STAS_IDX_W-1:0]    rd_idx,
	input  logic [`STAS_DATA_W-1:0]   rd_word
);
	import stas_pkg::*;

	wr_state_t wr_state;
	rd_state_t rd_state;

	// ------------------------------
	// Write channel
	// ------------------------------

	// Address and data are taken together, so one ready phase covers both
	always_ff @(posedge S1_AXI_ACLK or negedge S1_AXI_ARESETN)
	begin
		if (!S1_AXI_ARESETN)
		begin
			wr_state <= WR_IDLE;
		end
		else
		begin
			case (wr_state)
				WR_IDLE:
				begin
					// Wait until both channels present a beat
					if (awvalid && wvalid)
					begin
						wr_state <= WR_ACCEPT;
					end
				end
				WR_ACCEPT:
				begin
					// Ready lasts exactly one cycle
					wr_state <= WR_RESP;
				end
				WR_RESP:
				begin
					// Hold the response until the master takes it
					if (bready)
					begin
						wr_state <= WR_IDLE;
					end
				end
				default:
				begin
					wr_state <= WR_IDLE;
				end
			endcase
		end
	end

	// Ready and valid decode straight from the state register
	assign awready = (wr_state == WR_ACCEPT);
	assign wready  = (wr_state == WR_ACCEPT);
	assign bvalid  = (wr_state == WR_RESP);

	// Write lands in the queue at the end of the accept cycle
	assign wr_commit = (wr_state == WR_ACCEPT);

	// ------------------------------
	// Read channel
	// ------------------------------

	always_ff @(posedge S1_AXI_ACLK or negedge S1_AXI_ARESETN)
	begin
		if (!S1_AXI_ARESETN)
		begin
			rd_state <= RD_IDLE;
		end
		else
		begin
			case (rd_state)
				RD_IDLE:
				begin
					if (arvalid)
					begin
						rd_state <= RD_ACCEPT;
					end
				end
				RD_ACCEPT:
				begin
					rd_state <= RD_DATA;
				end
				RD_DATA:
				begin
					// Data stays on the bus until rready
					if (rready)
					begin
						rd_state <= RD_IDLE;
					end
				end
				default:
				begin
					rd_state <= RD_IDLE;
				end
			endcase
		end
	end

	assign arready    = (rd_state == RD_ACCEPT);
	assign rvalid     = (rd_state == RD_DATA);
	assign rd_capture = (rd_state == RD_ACCEPT);

	// Entry index, word offset taken from the read address
	always_ff @(posedge S1_AXI_ACLK)
	begin
		if ((rd_state == RD_IDLE) && arvalid)
		begin
			rd_idx <= araddr[`STAS_IDX_LSB +: `STAS_IDX_W];
		end
	end

	// Snapshot of the entry as it stood during the accept cycle
	always_ff @(posedge S1_AXI_ACLK)
	begin
		if (rd_capture)
		begin
			rdata <= rd_word;
		end
	end

endmodule

// File: hw/stas_fill_counter.sv
`timescale 1ns/1ns
`include "stas_macros.svh"

module stas_fill_counter
(
	input  logic                    S1_AXI_ACLK,
	input  logic                    S1_AXI_ARESETN,
	input  logic                    wr_commit,
	input  logic                    ready_to_transmit,
	output stas_pkg::q_op_t         q_op,
	output logic [`STAS_IDX_W-1:0]  tail_idx
);
	import stas_pkg::*;

	// Entries currently stored, 0 up to full
	logic [`STAS_CNT_W-1:0] count;
	logic                   push_ok;
	logic                   pop_ok;
	logic [`STAS_CNT_W-1:0] tail_cnt;

	// Writes into a full queue are dropped here
	assign push_ok = wr_commit && (count < `STAS_CNT_W'(`STAS_DEPTH));
	// Pop is a level, one entry per cycle
	assign pop_ok  = ready_to_transmit && (count != '0);

	always_comb
	begin
		case ({push_ok, pop_ok})
			2'b10:   q_op = Q_PUSH;
			2'b01:   q_op = Q_POP;
			2'b11:   q_op = Q_PUSH_POP;
			default: q_op = Q_HOLD;
		endcase
	end

	// On push with pop the queue shifts first, so the tail moves down one
	assign tail_cnt = (q_op == Q_PUSH_POP) ? count - 1'b1 : count;
	assign tail_idx = tail_cnt[`STAS_IDX_W-1:0];

	always_ff @(posedge S1_AXI_ACLK or negedge S1_AXI_ARESETN)
	begin
		if (!S1_AXI_ARESETN)
		begin
			count <= '0;
		end
		else
		begin
			case (q_op)
				Q_PUSH:  count <= count + 1'b1;
				Q_POP:   count <= count - 1'b1;
				// Push with pop leaves the count as it is
				default: count <= count;
			endcase
		end
	end

endmodule

// File: hw/stas_shift_queue.sv
`timescale 1ns/1ns
`include "stas_macros.svh"

module stas_shift_queue
(
	input  logic                    S1_AXI_ACLK,
	input  logic                    S1_AXI_ARESETN,
	// Operation decided by the fill counter
	input  stas_pkg::q_op_t         q_op,
	input  logic [`STAS_IDX_W-1:0]  tail_idx,
	// Write beat from the bus
	input  logic [`STAS_DATA_W-1:0] wdata,
	input  logic [`STAS_STRB_W-1:0] wstrb,
	// Random read port
	input  logic [`STAS_IDX_W-1:0]  rd_idx,
	output logic [`STAS_DATA_W-1:0] rd_word,
	// Last popped entry
	output logic [`STAS_DATA_W-1:0] head_word
);
	import stas_pkg::*;

	// Entry 0 is the head
	logic [`STAS_DATA_W-1:0] mem [0:`STAS_DEPTH-1];
	logic [`STAS_DATA_W-1:0] wr_word;
	logic                    push_en;
	logic                    pop_en;

	// ------------------------------
	// Operation decode
	// ------------------------------

	always_comb
	begin
		push_en = 1'b0;
		pop_en  = 1'b0;
		case (q_op)
			Q_PUSH:
			begin
				push_en = 1'b1;
			end
			Q_POP:
			begin
				pop_en = 1'b1;
			end
			Q_PUSH_POP:
			begin
				push_en = 1'b1;
				pop_en  = 1'b1;
			end
			default:
			begin
				push_en = 1'b0;
				pop_en  = 1'b0;
			end
		endcase
	end

	// Byte lanes without a strobe go in as zero
	always_comb
	begin
		for (int lane = 0; lane < `STAS_STRB_W; lane++)
		begin
			wr_word[lane*8 +: 8] = wstrb[lane] ? wdata[lane*8 +: 8] : 8'h00;
		end
	end

	// ------------------------------
	// Storage
	// ------------------------------

	always_ff @(posedge S1_AXI_ACLK or negedge S1_AXI_ARESETN)
	begin
		if (!S1_AXI_ARESETN)
		begin
			head_word <= '0;
			for (int i = 0; i < `STAS_DEPTH; i++)
			begin
				mem[i] <= '0;
			end
		end
		else
		begin
			if (pop_en)
			begin
				// Head goes out, the rest move one slot forward
				head_word <= mem[0];
				for (int i = 0; i < `STAS_DEPTH - 1; i++)
				begin
					mem[i] <= mem[i+1];
				end
				// Vacated last slot is cleared
				mem[`STAS_DEPTH-1] <= '0;
			end
			// Placed after the shift so the new word wins at tail_idx
			if (push_en)
			begin
				mem[tail_idx] <= wr_word;
			end
		end
	end

	// Combinational read, sampled by the read FSM
	assign rd_word = mem[rd_idx];

endmodule

// File: hw/stas_fifo_top.sv
`timescale 1ns/1ns
`include "stas_macros.svh"

module stas_fifo_top
(
	input  logic                    S1_AXI_ACLK,
	input  logic                    S1_AXI_ARESETN,
	// Write address channel
	input  logic [`STAS_ADDR_W-1:0] S1_AXI_AWADDR,
	input  logic                    S1_AXI_AWVALID,
	output logic                    S1_AXI_AWREADY,
	// Write data channel
	input  logic [`STAS_DATA_W-1:0] S1_AXI_WDATA,
	input  logic [`STAS_STRB_W-1:0] S1_AXI_WSTRB,
	input  logic                    S1_AXI_WVALID,
	output logic                    S1_AXI_WREADY,
	// Write response channel
	output logic [1:0]              S1_AXI_BRESP,
	output logic                    S1_AXI_BVALID,
	input  logic                    S1_AXI_BREADY,
	// Read address channel
	input  logic [`STAS_ADDR_W-1:0] S1_AXI_ARADDR,
	input  logic                    S1_AXI_ARVALID,
	output logic                    S1_AXI_ARREADY,
	// Read data channel
	output logic [`STAS_DATA_W-1:0] S1_AXI_RDATA,
	output logic [1:0]              S1_AXI_RRESP,
	output logic                    S1_AXI_RVALID,
	input  logic                    S1_AXI_RREADY,
	// Downstream initiator
	input  logic                    ready_to_transmit,
	output logic [`STAS_DATA_W-1:0] address_to_init
);
	import stas_pkg::*;

	logic                    wr_commit;
	logic                    rd_capture;
	logic [`STAS_IDX_W-1:0]  rd_idx;
	logic [`STAS_DATA_W-1:0] rd_word;
	q_op_t                   q_op;
	logic [`STAS_IDX_W-1:0]  tail_idx;

	// Always OKAY on both response channels
	assign S1_AXI_BRESP = 2'b00;
	assign S1_AXI_RRESP = 2'b00;

	// Writes go to the tail, S1_AXI_AWADDR is not decoded
	stas_axi_fsm i_axi_fsm
	(
		.S1_AXI_ACLK    (S1_AXI_ACLK),
		.S1_AXI_ARESETN (S1_AXI_ARESETN),
		.awvalid        (S1_AXI_AWVALID),
		.awready        (S1_AXI_AWREADY),
		.wvalid         (S1_AXI_WVALID),
		.wready         (S1_AXI_WREADY),
		.bvalid         (S1_AXI_BVALID),
		.bready         (S1_AXI_BREADY),
		.arvalid        (S1_AXI_ARVALID),
		.araddr         (S1_AXI_ARADDR),
		.arready        (S1_AXI_ARREADY),
		.rvalid         (S1_AXI_RVALID),
		.rdata          (S1_AXI_RDATA),
		.rready         (S1_AXI_RREADY),
		.wr_commit      (wr_commit),
		.rd_capture     (rd_capture),
		.rd_idx         (rd_idx),
		.rd_word        (rd_word)
	);

	stas_fill_counter i_fill_counter
	(
		.S1_AXI_ACLK       (S1_AXI_ACLK),
		.S1_AXI_ARESETN    (S1_AXI_ARESETN),
		.wr_commit         (wr_commit),
		.ready_to_transmit (ready_to_transmit),
		.q_op              (q_op),
		.tail_idx          (tail_idx)
	);

	// Popped head drives the initiator directly
	stas_shift_queue i_shift_queue
	(
		.S1_AXI_ACLK    (S1_AXI_ACLK),
		.S1_AXI_ARESETN (S1_AXI_ARESETN),
		.q_op           (q_op),
		.tail_idx       (tail_idx),
		.wdata          (S1_AXI_WDATA),
		.wstrb          (S1_AXI_WSTRB),
		.rd_idx         (rd_idx),
		.rd_word        (rd_word),
		.head_word      (address_to_init)
	);

endmodule

// File: bench/stas_fifo_tb_tasks.svh
`ifndef STAS_FIFO_TB_TASKS_SVH
`define STAS_FIFO_TB_TASKS_SVH

// ------------------------------
// Reference queue model
// ------------------------------

// Expected entries, index 0 is the head
logic [`STAS_DATA_W-1:0] model[$];
// Expected value on address_to_init
logic [`STAS_DATA_W-1:0] exp_head = '0;

// Lanes without a strobe are stored as zero
function automatic logic [31:0] strobe_mask(input logic [31:0] data, input logic [3:0] strb);
	return data & {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
endfunction

// Entries above the count read as zero
function automatic logic [31:0] model_entry(input int idx);
	if (idx < model.size())
		return model[idx];
	return '0;
endfunction

// One clock edge of the queue, full check before the pop frees a slot
task automatic advance_model();
	logic push_ok;
	push_ok = awready && wready && (model.size() < `STAS_DEPTH);
	if (ready_to_transmit && (model.size() != 0))
		exp_head = model.pop_front();
	if (push_ok)
		model.push_back(strobe_mask(wdata, wstrb));
endtask

// ------------------------------
// Bus master
// ------------------------------

// pop_too raises ready_to_transmit in the commit cycle only
task automatic write_beat(input logic [31:0] data, input logic [3:0] strb, input logic pop_too);
	awaddr  <= `STAS_ADDR_W'($urandom);
	awvalid <= 1'b1;
	wvalid  <= 1'b1;
	wdata   <= data;
	wstrb   <= strb;
	@(posedge S1_AXI_ACLK);
	ready_to_transmit <= pop_too;
	do @(posedge S1_AXI_ACLK); while (!(awready && wready));
	awvalid           <= 1'b0;
	wvalid            <= 1'b0;
	ready_to_transmit <= 1'b0;
endtask

// BREADY low for n cycles, then the response is taken
task automatic take_write_response(input int n);
	repeat (n) @(posedge S1_AXI_ACLK);
	bready <= 1'b1;
	do @(posedge S1_AXI_ACLK); while (!bvalid);
	bready <= 1'b0;
endtask

task automatic write_word(input logic [31:0] data, input logic [3:0] strb, input logic pop_too);
	write_beat(data, strb, pop_too);
	// Random stall on the response
	take_write_response($urandom_range(3));
endtask

// Next beat waits on the bus behind a held response
task automatic write_stalled(input logic [31:0] first, input logic [31:0] second);
	write_beat(first, 4'hF, 1'b0);
	awvalid <= 1'b1;
	wvalid  <= 1'b1;
	wdata   <= second;
	take_write_response(3);
	do @(posedge S1_AXI_ACLK); while (!(awready && wready));
	awvalid <= 1'b0;
	wvalid  <= 1'b0;
	take_write_response($urandom_range(3));
endtask

// RREADY low for n cycles, then the data is taken
task automatic take_read_data(input int n);
	repeat (n) @(posedge S1_AXI_ACLK);
	rready <= 1'b1;
	do @(posedge S1_AXI_ACLK); while (!rvalid);
	rready <= 1'b0;
endtask

// Value is checked by the monitor against the capture snapshot
task automatic read_entry(input logic [`STAS_IDX_W-1:0] idx);
	araddr  <= {idx, 2'b00};
	arvalid <= 1'b1;
	do @(posedge S1_AXI_ACLK); while (!arready);
	arvalid <= 1'b0;
	take_read_data($urandom_range(3));
endtask

// Next read waits on the bus behind held read data
task automatic read_stalled(input logic [`STAS_IDX_W-1:0] first,
	input logic [`STAS_IDX_W-1:0] second);
	araddr  <= {first, 2'b00};
	arvalid <= 1'b1;
	do @(posedge S1_AXI_ACLK); while (!arready);
	araddr <= {second, 2'b00};
	take_read_data(3);
	do @(posedge S1_AXI_ACLK); while (!arready);
	arvalid <= 1'b0;
	take_read_data($urandom_range(3));
endtask

task automatic read_all();
	for (int i = 0; i < `STAS_DEPTH; i++)
		read_entry(i[`STAS_IDX_W-1:0]);
endtask

// ready_to_transmit high for n cycles
task automatic pop_cycles(input int n);
	ready_to_transmit <= 1'b1;
	repeat (n) @(posedge S1_AXI_ACLK);
	ready_to_transmit <= 1'b0;
endtask

`endif

// File: bench/stas_fifo_tb.sv
`timescale 1ns/1ns
`include "stas_macros.svh"

module stas_fifo_tb;

	// About twice the cycles of all tests with worst case stalls
	localparam int CYCLE_LIMIT = 4000;

	logic S1_AXI_ACLK;
	logic S1_AXI_ARESETN;
	logic [`STAS_ADDR_W-1:0] awaddr, araddr;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [`STAS_DATA_W-1:0] wdata, rdata, address_to_init;
	logic [`STAS_STRB_W-1:0] wstrb;
	logic [1:0] bresp, rresp;
	logic ready_to_transmit;

	int unsigned cycles = 0;
	string test_name = "reset";
	// Entry value seen by the DUT in the read capture cycle
	logic [`STAS_DATA_W-1:0] cap_exp = '0;
	// Bus values of the previous cycle
	logic p_bvalid = 1'b0, p_bready = 1'b0, p_rvalid = 1'b0, p_rready = 1'b0;
	logic [`STAS_DATA_W-1:0] p_rdata = '0;

	`include "stas_fifo_tb_tasks.svh"

	stas_fifo_top i_dut
	(
		.S1_AXI_ACLK(S1_AXI_ACLK), .S1_AXI_ARESETN(S1_AXI_ARESETN),
		.S1_AXI_AWADDR(awaddr), .S1_AXI_AWVALID(awvalid), .S1_AXI_AWREADY(awready),
		.S1_AXI_WDATA(wdata), .S1_AXI_WSTRB(wstrb), .S1_AXI_WVALID(wvalid),
		.S1_AXI_WREADY(wready), .S1_AXI_BRESP(bresp), .S1_AXI_BVALID(bvalid),
		.S1_AXI_BREADY(bready), .S1_AXI_ARADDR(araddr), .S1_AXI_ARVALID(arvalid),
		.S1_AXI_ARREADY(arready), .S1_AXI_RDATA(rdata), .S1_AXI_RRESP(rresp),
		.S1_AXI_RVALID(rvalid), .S1_AXI_RREADY(rready),
		.ready_to_transmit(ready_to_transmit), .address_to_init(address_to_init)
	);

	task automatic stop_with_error(input string line);
		$display("** FAIL **");
		$display("%s", line);
		$fatal(1, "Stopped at first error");
	endtask

	function automatic string mismatch_line(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		return $sformatf("MISMATCH %s %s expected %h actual %h", test_name, what, expected, actual);
	endfunction

	initial
	begin
		S1_AXI_ACLK = 1'b0;
		forever #50 S1_AXI_ACLK = ~S1_AXI_ACLK;
	end

	// Watchdog
	always @(posedge S1_AXI_ACLK)
	begin
		cycles++;
		if (cycles > CYCLE_LIMIT)
			stop_with_error($sformatf("Timeout: run did not finish in test %s", test_name));
	end

	// ------------------------------
	// Monitor and checks
	// ------------------------------

	// Sampled at the edge, so every value is the one of the cycle just ended
	always @(posedge S1_AXI_ACLK)
	begin
		if (S1_AXI_ARESETN)
		begin
			// Held responses
			if (p_bvalid && !p_bready)
			begin
				assert (bvalid)
				else stop_with_error($sformatf("BVALID dropped before BREADY in %s", test_name));
			end
			if (p_rvalid && !p_rready)
			begin
				assert (rvalid)
				else stop_with_error($sformatf("RVALID dropped before RREADY in %s", test_name));
				assert (rdata == p_rdata)
				else stop_with_error(mismatch_line("held RDATA", p_rdata, rdata));
			end
			// No new accept while a response waits
			assert (!(bvalid && (awready || wready)))
			else stop_with_error("Write accepted with BVALID pending");
			assert (!(rvalid && arready))
			else stop_with_error("Read accepted with RVALID pending");
			assert (address_to_init == exp_head)
			else stop_with_error(mismatch_line("address_to_init", exp_head, address_to_init));
			if (bvalid && bready)
			begin
				assert (bresp == 2'b00)
				else stop_with_error(mismatch_line("BRESP", 32'h0, {30'b0, bresp}));
			end
			if (rvalid && rready)
			begin
				assert (rresp == 2'b00)
				else stop_with_error(mismatch_line("RRESP", 32'h0, {30'b0, rresp}));
				assert (rdata == cap_exp)
				else stop_with_error(mismatch_line("RDATA", cap_exp, rdata));
			end
			if (arready)
				cap_exp = model_entry(araddr[`STAS_IDX_LSB +: `STAS_IDX_W]);
			advance_model();
			p_bvalid = bvalid;
			p_bready = bready;
			p_rvalid = rvalid;
			p_rready = rready;
			p_rdata  = rdata;
		end
	end

	// ------------------------------
	// Test sequence
	// ------------------------------

	initial
	begin
		void'($urandom(78));
		S1_AXI_ARESETN = 1'b0;
		awaddr = '0;
		araddr = '0;
		wdata = '0;
		wstrb = '0;
		{awvalid, wvalid, bready, arvalid, rready, ready_to_transmit} = '0;
		repeat (10) @(posedge S1_AXI_ACLK);
		S1_AXI_ARESETN <= 1'b1;
		@(posedge S1_AXI_ACLK);
		assert (!(awready || wready || bvalid || arready || rvalid))
		else stop_with_error("Ready or valid output high after reset");
		read_all();
		test_name = "fill";
		repeat (20) write_word($urandom, 4'($urandom_range(15)), 1'b0);
		read_all();
		test_name = "pop";
		pop_cycles(10);
		read_all();
		// Fill to 32, then one write too many
		test_name = "full";
		repeat (`STAS_DEPTH + 1 - model.size()) write_word($urandom, 4'hF, 1'b0);
		read_all();
		pop_cycles(`STAS_DEPTH + 2);
		test_name = "push_pop";
		repeat (5) write_word($urandom, 4'($urandom_range(15)), 1'b0);
		write_word($urandom, 4'hF, 1'b1);
		write_word($urandom, 4'($urandom_range(15)), 1'b1);
		read_all();
		// A second request waits behind each held response
		test_name = "stall";
		write_stalled($urandom, $urandom);
		read_stalled(5'd0, 5'd6);
		pop_cycles(10);
		$display("** PASS **");
		$finish;
	end

endmodule

// File: compile.f
+incdir+hw
+incdir+bench
hw/stas_pkg.sv
hw/stas_axi_fsm.sv
hw/stas_fill_counter.sv
hw/stas_shift_queue.sv
hw/stas_fifo_top.sv
bench/stas_fifo_tb.sv

// File: Bender.yml
package:
  name: stas_fifo

sources:
  - include_dirs:
      - hw
    files:
      - hw/stas_pkg.sv
      - hw/stas_axi_fsm.sv
      - hw/stas_fill_counter.sv
      - hw/stas_shift_queue.sv
      - hw/stas_fifo_top.sv
  - target: simulation
    include_dirs:
      - hw
      - bench
    files:
      - bench/stas_fifo_tb.sv
